// File: logic/video_pkg.sv
package video_pkg;

	// ========================================
	// Video geometry
	// ========================================
	localparam int COORD_W = 11;                          // Pixel coordinate, up to 2047
	localparam int PIX_W   = 8;                           // One colour component
	localparam logic [COORD_W-1:0] H_ACTIVE = 11'd1920;   // Default window end x
	localparam logic [COORD_W-1:0] V_ACTIVE = 11'd1080;   // Default window end y

	// ========================================
	// Wishbone register map
	// ========================================
	localparam int WB_ADR_W = 3;
	localparam int WB_DAT_W = 16;
	localparam logic [WB_ADR_W-1:0] REG_START_X = 3'd0;
	localparam logic [WB_ADR_W-1:0] REG_START_Y = 3'd1;
	localparam logic [WB_ADR_W-1:0] REG_END_X   = 3'd2;
	localparam logic [WB_ADR_W-1:0] REG_END_Y   = 3'd3;
	localparam logic [WB_ADR_W-1:0] REG_CTRL    = 3'd4;
	localparam int CTRL_CROP_EN = 0;                      // Bit index in REG_CTRL

	// ========================================
	// Colour conversion, coefficients x256
	// ========================================
	localparam int COEF_W = 9;
	localparam int FRAC_W = 8;                            // Coefficient scale 2^8
	localparam int PROD_W = PIX_W + 1 + COEF_W;           // Signed pixel x coefficient
	localparam int SUM_W  = PROD_W + 2;                   // Room for three products
	typedef logic signed [COEF_W-1:0] coef_t;
	// Order R, G, B
	localparam coef_t Y_COEF  [3] = '{9'sd77, 9'sd150, 9'sd29};
	localparam coef_t CB_COEF [3] = '{-9'sd43, -9'sd85, 9'sd128};
	localparam coef_t CR_COEF [3] = '{9'sd128, -9'sd107, -9'sd21};
	localparam logic signed [SUM_W-1:0] CHROMA_OFFSET = 20'sd128;

	// Stream types
	typedef struct packed {
		logic hs;
		logic vs;
		logic de;
	} video_sync_t;

	typedef struct packed {
		logic [PIX_W-1:0] r;
		logic [PIX_W-1:0] g;
		logic [PIX_W-1:0] b;
	} rgb_pixel_t;

	typedef struct packed {
		video_sync_t sync;
		rgb_pixel_t  pix;
	} rgb_video_t;

	typedef struct packed {
		video_sync_t      sync;
		logic [PIX_W-1:0] y;
		logic [PIX_W-1:0] cb;
		logic [PIX_W-1:0] cr;
	} ycbcr_video_t;

	typedef struct packed {
		video_sync_t      sync;
		logic [PIX_W-1:0] y;
		logic [PIX_W-1:0] c;                              // Cb on even, Cr on odd pixels
	} yc422_video_t;

	// Window inclusive at start, exclusive at end
	typedef struct packed {
		logic [COORD_W-1:0] start_x;
		logic [COORD_W-1:0] start_y;
		logic [COORD_W-1:0] end_x;
		logic [COORD_W-1:0] end_y;
		logic               crop_en;
	} crop_cfg_t;

	localparam crop_cfg_t CROP_CFG_RST = '{
		start_x: '0, start_y: '0, end_x: H_ACTIVE, end_y: V_ACTIVE, crop_en: 1'b0
	};

	typedef struct packed {
		logic                cyc;
		logic                stb;
		logic                we;
		logic [WB_ADR_W-1:0] adr;
		logic [WB_DAT_W-1:0] dat;
	} wb_req_t;

	typedef struct packed {
		logic                ack;
		logic [WB_DAT_W-1:0] dat;
	} wb_rsp_t;

endpackage

// File: logic/param_regs.sv
`timescale 1ns/1ps

module param_regs (
	input  logic                 hdmi_rx_slow_clk,
	input  logic                 Sys_Rst_N,
	input  video_pkg::wb_req_t   i_wb,
	output video_pkg::wb_rsp_t   o_wb,
	output video_pkg::crop_cfg_t o_shadow_cfg
);
	import video_pkg::*;

	crop_cfg_t           cfg_q;     // Shadow settings, host side
	logic                ack_q;
	logic [WB_DAT_W-1:0] rd_dat_q;
	logic [WB_DAT_W-1:0] rd_mux;
	logic                wb_hit;    // New cycle, not yet acked
	logic                wb_wr;

	assign wb_hit = i_wb.cyc & i_wb.stb & ~ack_q;
	assign wb_wr  = wb_hit & i_wb.we;

	// Readback, unmapped addresses return zero
	always_comb begin
		rd_mux = '0;
		case (i_wb.adr)
			REG_START_X: rd_mux = WB_DAT_W'(cfg_q.start_x);
			REG_START_Y: rd_mux = WB_DAT_W'(cfg_q.start_y);
			REG_END_X:   rd_mux = WB_DAT_W'(cfg_q.end_x);
			REG_END_Y:   rd_mux = WB_DAT_W'(cfg_q.end_y);
			REG_CTRL:    rd_mux[CTRL_CROP_EN] = cfg_q.crop_en;
			default:     rd_mux = '0;
		endcase
	end

	always_ff @(posedge hdmi_rx_slow_clk or negedge Sys_Rst_N) begin
		if (!Sys_Rst_N) begin
			ack_q <= 1'b0;
			cfg_q <= CROP_CFG_RST;
		end else begin
			ack_q <= wb_hit;            // One-shot, drops while master still holds stb
			if (wb_wr) begin
				case (i_wb.adr)
					REG_START_X: cfg_q.start_x <= i_wb.dat[COORD_W-1:0];
					REG_START_Y: cfg_q.start_y <= i_wb.dat[COORD_W-1:0];
					REG_END_X:   cfg_q.end_x   <= i_wb.dat[COORD_W-1:0];
					REG_END_Y:   cfg_q.end_y   <= i_wb.dat[COORD_W-1:0];
					REG_CTRL:    cfg_q.crop_en <= i_wb.dat[CTRL_CROP_EN];
					default: ;                  // Acked, no effect
				endcase
			end
		end
	end

	// Read data captured together with ack
	always_ff @(posedge hdmi_rx_slow_clk) begin
		if (wb_hit)
			rd_dat_q <= rd_mux;
	end

	assign o_wb         = '{ack: ack_q, dat: rd_dat_q};
	assign o_shadow_cfg = cfg_q;

	// Ack only answers a request seen the cycle before
	a_ack_needs_req: assert property (@(posedge hdmi_rx_slow_clk) disable iff (!Sys_Rst_N)
		$rose(o_wb.ack) |-> $past(i_wb.cyc && i_wb.stb));

endmodule

// File: logic/frame_param_latch.sv
`timescale 1ns/1ps

module frame_param_latch (
	input  logic                 hdmi_rx_slow_clk,
	input  logic                 Sys_Rst_N,
	input  logic                 i_vs,
	input  video_pkg::crop_cfg_t i_shadow_cfg,
	output video_pkg::crop_cfg_t o_active_cfg
);
	import video_pkg::*;

	logic      vs_q;
	logic      vs_rise;
	crop_cfg_t active_q;

	assign vs_rise = i_vs & ~vs_q;  // Frame boundary

	always_ff @(posedge hdmi_rx_slow_clk or negedge Sys_Rst_N) begin
		if (!Sys_Rst_N) begin
			vs_q     <= 1'b0;
			active_q <= CROP_CFG_RST;
		end else begin
			vs_q <= i_vs;
			// Host writes never reach a frame already running
			if (vs_rise)
				active_q <= i_shadow_cfg;
		end
	end

	assign o_active_cfg = active_q;

	a_cfg_stable: assert property (@(posedge hdmi_rx_slow_clk) disable iff (!Sys_Rst_N)
		!vs_rise |=> $stable(o_active_cfg));

endmodule

// File: logic/crop_window.sv
`timescale 1ns/1ps

module crop_window (
	input  logic                  hdmi_rx_slow_clk,
	input  logic                  Sys_Rst_N,
	input  video_pkg::rgb_video_t i_video,
	input  video_pkg::crop_cfg_t  i_cfg,
	output video_pkg::rgb_video_t o_video
);
	import video_pkg::*;

	logic [COORD_W-1:0] x_cnt;      // Position of the pixel now at the input
	logic [COORD_W-1:0] y_cnt;
	video_sync_t        s1_sync;
	rgb_pixel_t         s1_pix;
	logic [COORD_W-1:0] s1_x;
	logic [COORD_W-1:0] s1_y;
	video_sync_t        s2_sync;
	rgb_pixel_t         s2_pix;
	logic               in_win;

	// ========================================
	// Position counters
	// ========================================
	always_ff @(posedge hdmi_rx_slow_clk or negedge Sys_Rst_N) begin
		if (!Sys_Rst_N) begin
			x_cnt <= '0;
			y_cnt <= '0;
		end else begin
			x_cnt <= i_video.sync.de ? x_cnt + 1'b1 : '0;
			if (i_video.sync.vs)
				y_cnt <= '0;
			else if (s1_sync.de && !i_video.sync.de)
				y_cnt <= y_cnt + 1'b1;              // End of an active line
		end
	end

	// Start inclusive, end exclusive
	assign in_win = (s1_x >= i_cfg.start_x) && (s1_x < i_cfg.end_x) &&
		(s1_y >= i_cfg.start_y) && (s1_y < i_cfg.end_y);

	// ========================================
	// Two-stage stream delay
	// ========================================
	always_ff @(posedge hdmi_rx_slow_clk or negedge Sys_Rst_N) begin
		if (!Sys_Rst_N) begin
			s1_sync <= '0;
			s2_sync <= '0;
		end else begin
			s1_sync    <= i_video.sync;
			s2_sync.hs <= s1_sync.hs;
			s2_sync.vs <= s1_sync.vs;
			s2_sync.de <= s1_sync.de & (~i_cfg.crop_en | in_win);   // Mask only de
		end
	end

	always_ff @(posedge hdmi_rx_slow_clk) begin
		s1_pix <= i_video.pix;
		s1_x   <= x_cnt;
		s1_y   <= y_cnt;
		s2_pix <= s1_pix;
	end

	assign o_video = '{sync: s2_sync, pix: s2_pix};

endmodule

// File: logic/rgb_to_ycbcr.sv
`timescale 1ns/1ps

module rgb_to_ycbcr (
	input  logic                    hdmi_rx_slow_clk,
	input  logic                    Sys_Rst_N,
	input  video_pkg::rgb_video_t   i_video,
	output video_pkg::ycbcr_video_t o_video
);
	import video_pkg::*;

	logic signed [PIX_W:0]    comp   [3];     // R, G, B as non-negative signed
	video_sync_t              sync_q [3];     // Follows the data, one per stage
	logic signed [PROD_W-1:0] prod_q [3][3];  // [Y, Cb, Cr][R, G, B]
	logic signed [SUM_W-1:0]  sum_q  [3];
	logic signed [SUM_W-1:0]  scaled [3];
	logic [PIX_W-1:0]         y_q;
	logic [PIX_W-1:0]         cb_q;
	logic [PIX_W-1:0]         cr_q;

	// Saturate to 0..255
	function automatic logic [PIX_W-1:0] clamp_pix(input logic signed [SUM_W-1:0] v);
		if (v[SUM_W-1])
			return '0;
		else if (|v[SUM_W-2:PIX_W])
			return '1;
		else
			return v[PIX_W-1:0];
	endfunction

	always_comb begin
		comp[0] = {1'b0, i_video.pix.r};
		comp[1] = {1'b0, i_video.pix.g};
		comp[2] = {1'b0, i_video.pix.b};
	end

	// Stage 1, nine products
	always_ff @(posedge hdmi_rx_slow_clk) begin
		for (int k = 0; k < 3; k++) begin
			prod_q[0][k] <= comp[k] * Y_COEF[k];
			prod_q[1][k] <= comp[k] * CB_COEF[k];
			prod_q[2][k] <= comp[k] * CR_COEF[k];
		end
	end

	// Stage 2, full precision sums
	always_ff @(posedge hdmi_rx_slow_clk) begin
		for (int c = 0; c < 3; c++)
			sum_q[c] <= prod_q[c][0] + prod_q[c][1] + prod_q[c][2];
	end

	// Arithmetic shift gives floor
	always_comb begin
		scaled[0] = sum_q[0] >>> FRAC_W;
		scaled[1] = (sum_q[1] >>> FRAC_W) + CHROMA_OFFSET;
		scaled[2] = (sum_q[2] >>> FRAC_W) + CHROMA_OFFSET;
	end

	// Stage 3, clamp and register
	always_ff @(posedge hdmi_rx_slow_clk) begin
		y_q  <= clamp_pix(scaled[0]);
		cb_q <= clamp_pix(scaled[1]);
		cr_q <= clamp_pix(scaled[2]);
	end

	always_ff @(posedge hdmi_rx_slow_clk or negedge Sys_Rst_N) begin
		if (!Sys_Rst_N) begin
			sync_q[0] <= '0;
			sync_q[1] <= '0;
			sync_q[2] <= '0;
		end else begin
			sync_q[0] <= i_video.sync;
			sync_q[1] <= sync_q[0];
			sync_q[2] <= sync_q[1];
		end
	end

	assign o_video = '{sync: sync_q[2], y: y_q, cb: cb_q, cr: cr_q};

endmodule

// File: logic/chroma_subsample.sv
`timescale 1ns/1ps

module chroma_subsample (
	input  logic                    hdmi_rx_slow_clk,
	input  logic                    Sys_Rst_N,
	input  video_pkg::ycbcr_video_t i_video,
	output video_pkg::yc422_video_t o_video
);
	import video_pkg::*;

	logic             phase_q;      // 0 on even pixel of the line
	video_sync_t      sync_q;
	logic [PIX_W-1:0] y_q;
	logic [PIX_W-1:0] c_q;
	logic [PIX_W-1:0] cr_hold;      // Cr of the last even pixel

	always_ff @(posedge hdmi_rx_slow_clk or negedge Sys_Rst_N) begin
		if (!Sys_Rst_N) begin
			phase_q <= 1'b0;
			sync_q  <= '0;
		end else begin
			phase_q <= i_video.sync.de ? ~phase_q : 1'b0;  // Restart every line
			sync_q  <= i_video.sync;
		end
	end

	always_ff @(posedge hdmi_rx_slow_clk) begin
		y_q <= i_video.y;
		if (!phase_q) begin
			c_q     <= i_video.cb;
			cr_hold <= i_video.cr;
		end else begin
			c_q <= cr_hold;             // Pair shares the even pixel's Cr
		end
	end

	assign o_video = '{sync: sync_q, y: y_q, c: c_q};

	// Each line opens with a Cb sample
	a_phase_even: assert property (@(posedge hdmi_rx_slow_clk) disable iff (!Sys_Rst_N)
		$rose(i_video.sync.de) |-> !phase_q);

endmodule

// File: logic/video_proc_top.sv
`timescale 1ns/1ps

module video_proc_top (
	input  logic                    hdmi_rx_slow_clk,
	input  logic                    Sys_Rst_N,
	input  video_pkg::wb_req_t      i_wb,
	output video_pkg::wb_rsp_t      o_wb,
	input  video_pkg::rgb_video_t   i_video,
	output video_pkg::yc422_video_t o_video
);
	import video_pkg::*;

	crop_cfg_t    shadow_cfg;   // Host side settings
	crop_cfg_t    active_cfg;   // Frame-aligned copy
	rgb_video_t   crop_video;
	ycbcr_video_t ycc_video;

	// ========================================
	// Register path
	// ========================================
	param_regs u_param_regs (
		.hdmi_rx_slow_clk (hdmi_rx_slow_clk),
		.Sys_Rst_N        (Sys_Rst_N),
		.i_wb             (i_wb),
		.o_wb             (o_wb),
		.o_shadow_cfg     (shadow_cfg)
	);

	frame_param_latch u_frame_param_latch (
		.hdmi_rx_slow_clk (hdmi_rx_slow_clk),
		.Sys_Rst_N        (Sys_Rst_N),
		.i_vs             (i_video.sync.vs),
		.i_shadow_cfg     (shadow_cfg),
		.o_active_cfg     (active_cfg)
	);

	// ========================================
	// Video chain, 2 + 3 + 1 cycles
	// ========================================
	crop_window u_crop_window (
		.hdmi_rx_slow_clk (hdmi_rx_slow_clk),
		.Sys_Rst_N        (Sys_Rst_N),
		.i_video          (i_video),
		.i_cfg            (active_cfg),
		.o_video          (crop_video)
	);

	rgb_to_ycbcr u_rgb_to_ycbcr (
		.hdmi_rx_slow_clk (hdmi_rx_slow_clk),
		.Sys_Rst_N        (Sys_Rst_N),
		.i_video          (crop_video),
		.o_video          (ycc_video)
	);

	chroma_subsample u_chroma_subsample (
		.hdmi_rx_slow_clk (hdmi_rx_slow_clk),
		.Sys_Rst_N        (Sys_Rst_N),
		.i_video          (ycc_video),
		.o_video          (o_video)
	);

endmodule

// File: verification/tb_video_proc.sv
`timescale 1ns/1ps

module tb_video_proc;
	import video_pkg::*;

	logic             hdmi_rx_slow_clk;
	logic             Sys_Rst_N;
	wb_req_t          wb_req;
	wb_rsp_t          wb_rsp;
	rgb_video_t       vid_in;
	yc422_video_t     vid_out;

	yc422_video_t     got_q [$];        // De-high output samples in arrival order
	rgb_pixel_t       frame_mem [0:63]; // Raster order
	int               frame_w;
	int               frame_h;
	int               fd;
	logic [8*24-1:0]  test_name;
	logic [8*200-1:0] skip_line;
	logic             pend_valid;       // Write queued for the next frame
	int               pend_line;
	logic [31:0]      pend_adr;
	logic [31:0]      pend_dat;
	int               n_checks;
	int               val_errs;
	int               other_errs;

	video_proc_top i_dut (
		.hdmi_rx_slow_clk (hdmi_rx_slow_clk),
		.Sys_Rst_N        (Sys_Rst_N),
		.i_wb             (wb_req),
		.o_wb             (wb_rsp),
		.i_video          (vid_in),
		.o_video          (vid_out)
	);

	always #2 hdmi_rx_slow_clk = ~hdmi_rx_slow_clk;   // 4 ns period

	// Output collector
	always @(negedge hdmi_rx_slow_clk) begin
		if (Sys_Rst_N && vid_out.sync.de)
			got_q.push_back(vid_out);
	end

	// ========================================
	// Compare tasks
	// ========================================
	task automatic check_wb(input wb_rsp_t exp, input wb_rsp_t act);
		n_checks++;
		if (act !== exp) begin
			val_errs++;
			$display("[ERROR] %0s: expected ack=%0b dat=%h, actual ack=%0b dat=%h",
				test_name, exp.ack, exp.dat, act.ack, act.dat);
		end
	endtask

	task automatic check_yc(input yc422_video_t exp, input yc422_video_t act);
		n_checks++;
		if (act !== exp) begin
			val_errs++;
			$display("[ERROR] %0s: expected y=%h c=%h sync=%b, actual y=%h c=%h sync=%b",
				test_name, exp.y, exp.c, exp.sync, act.y, act.c, act.sync);
		end
	endtask

	// ========================================
	// Drivers
	// ========================================
	task automatic wb_access(input logic wr, input logic [31:0] adr, input logic [31:0] dat,
			output wb_rsp_t rsp);
		int waited;
		waited = 0;
		rsp    = '0;
		@(negedge hdmi_rx_slow_clk);
		wb_req = '{cyc: 1'b1, stb: 1'b1, we: wr,
			adr: adr[WB_ADR_W-1:0], dat: dat[WB_DAT_W-1:0]};
		while (!wb_rsp.ack && waited < 16) begin    // Master holds until ack
			@(negedge hdmi_rx_slow_clk);
			waited++;
		end
		if (wb_rsp.ack) begin
			rsp = wb_rsp;
		end else begin
			other_errs++;
			$display("Timeout in test %0s: no Wishbone ack within 16 cycles at address %0d",
				test_name, adr);
		end
		wb_req = '0;
	endtask

	task automatic drive_video(input logic hs, input logic vs, input logic de,
			input rgb_pixel_t pix);
		@(negedge hdmi_rx_slow_clk);
		vid_in = '{sync: '{hs: hs, vs: vs, de: de}, pix: pix};
	endtask

	task automatic send_frame();
		wb_rsp_t rsp;
		int      row;
		int      col;
		repeat (3) drive_video(1'b0, 1'b1, 1'b0, '0);   // Vsync pulse
		for (row = 0; row < frame_h; row++) begin
			for (col = 0; col < frame_w; col++)
				drive_video(1'b0, 1'b0, 1'b1, frame_mem[row * frame_w + col]);
			drive_video(1'b1, 1'b0, 1'b0, '0);          // Hsync in the gap
			repeat (3) drive_video(1'b0, 1'b0, 1'b0, '0);
			// Host write while the frame runs
			if (pend_valid && pend_line == row) begin
				wb_access(1'b1, pend_adr, pend_dat, rsp);
				pend_valid = 1'b0;
			end
		end
		repeat (8) drive_video(1'b0, 1'b0, 1'b0, '0);   // Trailing blank
	endtask

	task automatic load_frame();
		logic [31:0] pix;
		int          rc;
		int          k;
		rc = $fscanf(fd, "%d %d", frame_w, frame_h);
		for (k = 0; k < frame_w * frame_h; k++) begin
			rc = $fscanf(fd, "%h", pix);
			frame_mem[k] = pix[23:0];
		end
	endtask

	// ========================================
	// Checkers
	// ========================================
	task automatic idle_check(input int n);
		int k;
		for (k = 0; k < n; k++) begin
			@(negedge hdmi_rx_slow_clk);
			n_checks++;
			if (wb_rsp.ack !== 1'b0 || vid_out.sync !== 3'b000) begin
				val_errs++;
				$display("[ERROR] %0s: expected ack=0 sync=000, actual ack=%0b sync=%b",
					test_name, wb_rsp.ack, vid_out.sync);
			end
		end
	endtask

	task automatic expect_samples(input int n);
		yc422_video_t exp;
		logic [31:0]  tok;
		int           rc;
		int           t;
		int           k;
		t = 0;
		while (got_q.size() < n && t < 64) begin
			@(negedge hdmi_rx_slow_clk);
			t++;
		end
		if (got_q.size() < n) begin
			other_errs++;
			$display("Timeout in test %0s: only %0d of %0d output samples arrived",
				test_name, got_q.size(), n);
		end
		for (k = 0; k < n; k++) begin
			rc  = $fscanf(fd, "%h", tok);           // {Y, C}
			exp = '{sync: '{hs: 1'b0, vs: 1'b0, de: 1'b1}, y: tok[15:8], c: tok[7:0]};
			if (got_q.size() > 0)
				check_yc(exp, got_q.pop_front());
		end
		if (got_q.size() != 0) begin
			other_errs++;
			$display("Test %0s: %0d output samples more than expected", test_name, got_q.size());
			got_q.delete();
		end
	endtask

	task automatic run_patterns();
		wb_rsp_t     rsp;
		wb_rsp_t     exp_rsp;
		logic [7:0]  op;
		logic [31:0] a;
		logic [31:0] b;
		int          rc;
		while ($fscanf(fd, "%s", op) == 1) begin
			case (op)
				"#": rc = $fgets(skip_line, fd);        // Comment line
				"T": rc = $fscanf(fd, "%s", test_name);
				"I": begin
					rc = $fscanf(fd, "%d", a);
					idle_check(a);
				end
				"W": begin
					rc = $fscanf(fd, "%h %h", a, b);
					wb_access(1'b1, a, b, rsp);
				end
				"R": begin
					rc      = $fscanf(fd, "%h %h", a, b);
					exp_rsp = '{ack: 1'b1, dat: b[WB_DAT_W-1:0]};
					wb_access(1'b0, a, 32'd0, rsp);
					check_wb(exp_rsp, rsp);
				end
				"P": begin
					rc         = $fscanf(fd, "%d %h %h", pend_line, pend_adr, pend_dat);
					pend_valid = 1'b1;
				end
				"F": load_frame();
				"S": send_frame();
				"E": begin
					rc = $fscanf(fd, "%d", a);
					expect_samples(a);
				end
				default: begin
					other_errs++;
					$display("Unknown pattern op %s in test %0s", op, test_name);
				end
			endcase
		end
	endtask

	initial begin
		hdmi_rx_slow_clk = 1'b0;
		Sys_Rst_N        = 1'b0;
		wb_req           = '0;
		vid_in           = '0;
		pend_valid       = 1'b0;
		pend_line        = 0;
		n_checks         = 0;
		val_errs         = 0;
		other_errs       = 0;
		test_name        = "startup";
		repeat (10) @(negedge hdmi_rx_slow_clk);
		Sys_Rst_N = 1'b1;
		fd = $fopen("verification/video_patterns.txt", "r");
		if (fd == 0) begin
			other_errs++;
			$display("Cannot open verification/video_patterns.txt");
		end else begin
			run_patterns();
			$fclose(fd);
		end
		$display("Summary: %0d checks, %0d value errors, %0d other errors",
			n_checks, val_errs, other_errs);
		if (val_errs == 0 && other_errs == 0 && n_checks > 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

endmodule

// File: verification/video_patterns.txt
# T name | W adr dat | R adr rd_dat | I idle_cycles | P line adr dat = write after that line of next S
# F w h then w*h pixels RRGGBB | S = send frame | E n then n output samples YYCC
T reset_idle
I 20
T reg_readback
W 0 0123  W 1 0456  W 2 07FF  W 3 0001  W 4 0001  W 7 BEEF
R 0 0123  R 1 0456  R 2 07FF  R 3 0001  R 4 0001
R 5 0000  R 7 0000
W 4 0000
F 8 4
FF0000 00FF00 0000FF 204060 000000 FFFFFF FF0000 00FF00
00FF00 0000FF 204060 000000 FFFFFF FF0000 00FF00 0000FF
0000FF 204060 000000 FFFFFF FF0000 00FF00 0000FF 204060
204060 000000 FFFFFF FF0000 00FF00 0000FF 204060 000000
T full_frame
S
E 32
4C55 95FF 1CFF 3A6B 0080 FF80 4C55 95FF
952B 1C15 3A95 006D FF80 4C80 952B 1C15
1CFF 3A6B 0080 FF80 4C55 95FF 1CFF 3A6B
3A95 006D FF80 4C80 952B 1C15 3A95 006D
T crop_window
W 0 0002  W 1 0001  W 2 0006  W 3 0003  W 4 0001
S
E 8 3A95 006D FF80 4C80 0080 FF80 4C55 95FF
T mid_frame_write
P 0 0 0004
S
E 8 3A95 006D FF80 4C80 0080 FF80 4C55 95FF
S
E 4 FF80 4C80 4C55 95FF
T odd_width
W 0 0001  W 1 0000  W 2 0004  W 3 0002
S
E 6 952B 1C15 3A95 1CFF 3A6B 0080

// File: tb.f
logic/video_pkg.sv
logic/param_regs.sv
logic/frame_param_latch.sv
logic/crop_window.sv
logic/rgb_to_ycbcr.sv
logic/chroma_subsample.sv
logic/video_proc_top.sv
verification/tb_video_proc.sv

// File: run_sim.sh
#!/bin/sh
# Compile and run the video path testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_video_proc -f tb.f -o sim_video_proc

./obj_dir/sim_video_proc | tee sim.log

if grep -qF '*** PASSED ***' sim.log; then
	echo "Simulation result: pass"
	exit 0
fi
echo "Simulation result: fail"
exit 1
